//--- include/uart_rx_defines.svh
`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

////////////////////
// receiver timing
////////////////////

// clock cycles per serial bit, 4 or more.
`define RX_CLKS_PER_BIT 16

////////////////////
// frame format
////////////////////

`define RX_PARITY_ODD 0 // 0 even, 1 odd.

`endif

//--- src/uart_rx_pkg.sv
`default_nettype none

`include "uart_rx_defines.svh"

package uart_rx_pkg;

    typedef logic [7:0] rx_byte_t; // one received data byte.

    // holds 0 .. RX_CLKS_PER_BIT-1.
    typedef logic [$clog2(`RX_CLKS_PER_BIT)-1:0] bit_count_t;

    // data states are consecutive so they can be stepped by +1.
    typedef enum logic [3:0] {
        RX_IDLE       = 4'd0,
        RX_START_BIT  = 4'd1,
        RX_DATA_BIT_0 = 4'd2,
        RX_DATA_BIT_1 = 4'd3,
        RX_DATA_BIT_2 = 4'd4,
        RX_DATA_BIT_3 = 4'd5,
        RX_DATA_BIT_4 = 4'd6,
        RX_DATA_BIT_5 = 4'd7,
        RX_DATA_BIT_6 = 4'd8,
        RX_DATA_BIT_7 = 4'd9,
        RX_PARITY_BIT = 4'd10,
        RX_STOP_BIT   = 4'd11
    } rx_state_t;

endpackage

`default_nettype wire

//--- src/rx_line_sync.sv
`timescale 1ns/100ps
`default_nettype none

module rx_line_sync (
    input  logic clk,
    input  logic reset,
    input  logic rx,       // asynchronous serial line.
    output logic rx_sync,
    output logic rx_fall
);

    logic rx_meta; // first synchronizer stage.
    logic rx_prev; // rx_sync one cycle ago.

    ////////////////////
    // synchronizer
    ////////////////////

    // line idles high, so every stage resets to 1.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    ////////////////////
    // edge detect
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            rx_fall <= 1'b0;
        else
            rx_fall <= rx_prev & ~rx_sync; // high-to-low seen last cycle.
    end

endmodule

`default_nettype wire

//--- src/rx_bit_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_defines.svh"

module rx_bit_timer
    import uart_rx_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic rx_fall,
    output logic sampling_strobe
);

    localparam int last_count = `RX_CLKS_PER_BIT - 1;

    // count is 0 the cycle after the edge and the strobe is registered,
    // so firing at HALF-2 puts the strobe RX_CLKS_PER_BIT/2 cycles after rx_fall.
    localparam int strobe_count = `RX_CLKS_PER_BIT / 2 - 2;

    bit_count_t count;

    ////////////////////
    // bit period counter
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (rx_fall)
            count <= '0; // realign on every edge.
        else if (count == bit_count_t'(last_count))
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // mid-bit strobe.
    always_ff @(posedge clk)
    begin
        if (reset)
            sampling_strobe <= 1'b0;
        else
            sampling_strobe <= !rx_fall && (count == bit_count_t'(strobe_count));
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count < `RX_CLKS_PER_BIT
    );

endmodule

`default_nettype wire

//--- src/rx_state.sv
`timescale 1ns/100ps
`default_nettype none

module rx_state
    import uart_rx_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start_detected,    // line currently low.
    input  logic sampling_strobe,   // centre of a bit.
    output logic data_is_available,
    output logic data_is_valid,
    output logic is_parity_stage
);

    rx_state_t state;

    ////////////////////
    // frame sequencer
    ////////////////////

    // one step per strobe.
    always_ff @(posedge clk)
    begin
        if (reset)
            state <= RX_IDLE;
        else if (sampling_strobe)
        begin
            case (state)
                RX_IDLE:
                    // still low at mid-bit, so not a glitch.
                    state <= start_detected ? RX_START_BIT : RX_IDLE;
                RX_START_BIT:
                    state <= RX_DATA_BIT_0;
                RX_DATA_BIT_0,
                RX_DATA_BIT_1,
                RX_DATA_BIT_2,
                RX_DATA_BIT_3,
                RX_DATA_BIT_4,
                RX_DATA_BIT_5,
                RX_DATA_BIT_6:
                    state <= rx_state_t'(state + 1'b1);
                RX_DATA_BIT_7:
                    state <= RX_PARITY_BIT;
                RX_PARITY_BIT:
                    state <= RX_STOP_BIT;
                RX_STOP_BIT:
                    state <= RX_IDLE;
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // level outputs, one cycle behind the state.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_is_available <= 1'b0;
            is_parity_stage   <= 1'b0;
            data_is_valid     <= 1'b0;
        end
        else
        begin
            data_is_available <= (state >= RX_DATA_BIT_0) && (state <= RX_DATA_BIT_7);
            is_parity_stage   <= (state == RX_PARITY_BIT);
            data_is_valid     <= (state == RX_STOP_BIT); // frame complete.
        end
    end

    state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {[RX_IDLE:RX_STOP_BIT]}
    );

    // no movement between strobes.
    state_moves_on_strobe: assert property (
        @(posedge clk) disable iff (reset)
        $changed(state) |-> $past(sampling_strobe)
    );

endmodule

`default_nettype wire

//--- src/rx_data_path.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_defines.svh"

module rx_data_path
    import uart_rx_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     rx_sync,
    input  logic     sampling_strobe,
    input  logic     data_is_available,
    input  logic     is_parity_stage,
    input  logic     data_is_valid,
    output rx_byte_t rx_data,
    output logic     rx_valid,
    output logic     parity_error,
    output logic     framing_error
);

    logic     strobe_d1;
    logic     strobe_d2;  // lines up with the sequencer levels.
    rx_byte_t shift_reg;
    logic     parity_bit;
    logic     parity_calc;

    // expected parity bit for the byte.
    assign parity_calc = (^shift_reg) ^ 1'(`RX_PARITY_ODD);

    ////////////////////
    // strobe alignment
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            strobe_d1 <= 1'b0;
            strobe_d2 <= 1'b0;
        end
        else
        begin
            strobe_d1 <= sampling_strobe;
            strobe_d2 <= strobe_d1;
        end
    end

    ////////////////////
    // capture
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shift_reg  <= '0;
            parity_bit <= 1'b0;
            rx_data    <= '0;
        end
        else
        begin
            if (strobe_d2 && data_is_available)
                shift_reg <= {rx_sync, shift_reg[7:1]}; // new bit enters at the top.
            if (strobe_d2 && is_parity_stage)
                parity_bit <= rx_sync;
            if (strobe_d2 && data_is_valid)
                rx_data <= shift_reg;
        end
    end

    // flags hold until the next stop bit.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_valid      <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end
        else
        begin
            rx_valid <= strobe_d2 && data_is_valid;
            if (strobe_d2 && data_is_valid)
            begin
                parity_error  <= (parity_bit != parity_calc);
                framing_error <= !rx_sync; // stop bit must be high.
            end
        end
    end

    valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid
    );

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_rx_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     rx,
    output rx_byte_t rx_data,
    output logic     rx_valid,
    output logic     parity_error,
    output logic     framing_error
);

    logic rx_sync;
    logic rx_fall;
    logic sampling_strobe;
    logic start_detected;
    logic data_is_available;
    logic data_is_valid;
    logic is_parity_stage;

    assign start_detected = ~rx_sync; // line held low.

    ////////////////////
    // front end
    ////////////////////

    rx_line_sync u_rx_line_sync (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_sync (rx_sync),
        .rx_fall (rx_fall)
    );

    rx_bit_timer u_rx_bit_timer (
        .clk             (clk),
        .reset           (reset),
        .rx_fall         (rx_fall),
        .sampling_strobe (sampling_strobe)
    );

    ////////////////////
    // frame handling
    ////////////////////

    rx_state u_rx_state (
        .clk               (clk),
        .reset             (reset),
        .start_detected    (start_detected),
        .sampling_strobe   (sampling_strobe),
        .data_is_available (data_is_available),
        .data_is_valid     (data_is_valid),
        .is_parity_stage   (is_parity_stage)
    );

    rx_data_path u_rx_data_path (
        .clk               (clk),
        .reset             (reset),
        .rx_sync           (rx_sync),
        .sampling_strobe   (sampling_strobe),
        .data_is_available (data_is_available),
        .is_parity_stage   (is_parity_stage),
        .data_is_valid     (data_is_valid),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .parity_error      (parity_error),
        .framing_error     (framing_error)
    );

endmodule

`default_nettype wire

//--- verification/uart_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_defines.svh"

module uart_rx_tb
    import uart_rx_pkg::*;
();

    localparam int    clks_per_bit  = `RX_CLKS_PER_BIT;
    localparam int    random_frames = 20;
    localparam string cases_file    = "verification/uart_rx_cases.txt";

    logic     clk;
    logic     reset;
    logic     rx;
    rx_byte_t rx_data;
    logic     rx_valid;
    logic     parity_error;
    logic     framing_error;

    // frames read from the cases file.
    rx_byte_t case_data_q[$];
    logic     case_corrupt_q[$];
    logic     case_stop_q[$];
    logic     case_glitch_q[$];

    // results still owed by the DUT in send order.
    rx_byte_t exp_data_q[$];
    logic     exp_perr_q[$];
    logic     exp_ferr_q[$];

    int          error_count;
    int          valid_count;
    int          expected_valid;
    int          cycle_count;
    int          cycle_limit;
    logic        first_frame_sent;
    logic [31:0] lcg_state;

    uart_rx u_uart_rx (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .parity_error  (parity_error),
        .framing_error (framing_error)
    );

    always #5 clk = ~clk;

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // correct parity bit for a byte.
    function automatic logic parity_of(input rx_byte_t data);
        return (^data) ^ (`RX_PARITY_ODD != 0);
    endfunction

    // holds rx at a value for a number of cycles from just after an edge.
    task automatic drive_bit(input logic value, input int cycles);
        @(posedge clk);
        #1;
        rx = value;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic send_frame(input rx_byte_t data, input logic corrupt, input logic stop);
        logic parity;
        parity = parity_of(data) ^ corrupt;
        exp_data_q.push_back(data);
        exp_perr_q.push_back(corrupt);
        exp_ferr_q.push_back(!stop);
        expected_valid++;
        first_frame_sent = 1'b1;
        drive_bit(1'b0, clks_per_bit); // start bit.
        for (int i = 0; i < 8; i++)
            drive_bit(data[i], clks_per_bit);
        drive_bit(parity, clks_per_bit);
        drive_bit(stop, clks_per_bit);
        drive_bit(1'b1, 2 * clks_per_bit); // idle gap.
    endtask

    // short low pulse and then idle for the rest of three bit times.
    task automatic send_glitch();
        drive_bit(1'b0, clks_per_bit / 4);
        drive_bit(1'b1, clks_per_bit - clks_per_bit / 4);
        drive_bit(1'b1, 2 * clks_per_bit);
    endtask

    ////////////////////
    // output checks
    ////////////////////

    always @(negedge clk)
    begin : check_output
        rx_byte_t exp_data;
        logic     exp_perr;
        logic     exp_ferr;
        if (!reset)
        begin
            if (!first_frame_sent)
            begin
                assert (!rx_valid)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t: rx_valid high before any frame was sent", $time);
                end
            end
            if (rx_valid)
            begin
                valid_count++;
                assert (exp_data_q.size() != 0)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t: rx_valid with no frame outstanding", $time);
                end
                if (exp_data_q.size() != 0)
                begin
                    exp_data = exp_data_q.pop_front();
                    exp_perr = exp_perr_q.pop_front();
                    exp_ferr = exp_ferr_q.pop_front();
                    assert (rx_data == exp_data)
                    else
                    begin
                        error_count++;
                        $display("[ERROR] %0t: rx_data %h, expected %h",
                                 $time, rx_data, exp_data);
                    end
                    assert (parity_error == exp_perr)
                    else
                    begin
                        error_count++;
                        $display("[ERROR] %0t: parity_error %b, expected %b (byte %h)",
                                 $time, parity_error, exp_perr, exp_data);
                    end
                    assert (framing_error == exp_ferr)
                    else
                    begin
                        error_count++;
                        $display("[ERROR] %0t: framing_error %b, expected %b (byte %h)",
                                 $time, framing_error, exp_ferr, exp_data);
                    end
                end
            end
        end
    end

    // watchdog.
    initial
    begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles without finishing", cycle_count);
        $display("errors: %0d, frames sent: %0d, bytes received: %0d",
                 error_count, expected_valid, valid_count);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        int         fd;
        int         fields;
        string      line;
        logic [7:0] case_byte;
        int         case_corrupt;
        int         case_stop;
        int         case_glitch;

        clk              = 1'b0;
        reset            = 1'b1;
        rx               = 1'b1;
        error_count      = 0;
        valid_count      = 0;
        expected_valid   = 0;
        cycle_count      = 0;
        cycle_limit      = 0;
        first_frame_sent = 1'b0;

        fd = $fopen(cases_file, "r");
        if (fd == 0)
        begin
            error_count++;
            $display("could not open %s, no file cases will run", cases_file);
        end
        while (fd != 0 && !$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %d %d %d", case_byte, case_corrupt, case_stop,
                             case_glitch);
            if (fields == 4) // comment and blank lines fall through.
            begin
                case_data_q.push_back(case_byte);
                case_corrupt_q.push_back(case_corrupt != 0);
                case_stop_q.push_back(case_stop != 0);
                case_glitch_q.push_back(case_glitch != 0);
            end
        end
        if (fd != 0)
            $fclose(fd);

        cycle_limit = (case_data_q.size() + random_frames) * 14 * clks_per_bit + 200;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_bit(1'b1, 2 * clks_per_bit); // quiet line before the first frame.

        for (int i = 0; i < case_data_q.size(); i++)
        begin
            if (case_glitch_q[i])
                send_glitch();
            else
                send_frame(case_data_q[i], case_corrupt_q[i], case_stop_q[i]);
        end

        lcg_state = 32'd6759;
        repeat (random_frames)
        begin
            lcg_state = lcg_next(lcg_state);
            send_frame(lcg_state[23:16], 1'b0, 1'b1);
        end

        while (exp_data_q.size() != 0)
            @(negedge clk);
        drive_bit(1'b1, 2 * clks_per_bit); // catch any stray pulse.

        assert (valid_count == expected_valid)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: %0d rx_valid pulses, expected %0d",
                     $time, valid_count, expected_valid);
        end

        $display("errors: %0d, frames sent: %0d, bytes received: %0d",
                 error_count, expected_valid, valid_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/uart_rx_cases.txt
# byte(hex) parity_corrupt stop_bit glitch
# glitch lines send only a short low pulse, their byte is ignored
00 0 1 0
FF 0 1 0
55 0 1 0
AA 0 1 0
01 0 1 0
80 0 1 0
3C 1 1 0
C3 1 1 0
00 1 1 0
FF 1 1 0
5A 0 0 0
A5 1 0 0
00 0 0 0
00 0 1 1
7E 0 1 0
00 0 1 1
00 0 1 1
E7 0 1 0
12 1 0 0
FE 0 1 0

//--- compile.f
+incdir+include
src/uart_rx_pkg.sv
src/rx_line_sync.sv
src/rx_bit_timer.sv
src/rx_state.sv
src/rx_data_path.sv
src/uart_rx.sv
verification/uart_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_rx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
